/* hw/sobel_params.svh */
//----------------------------------------------------------
// Sobel edge engine shared constants
// Bus widths, register map and read-back values
//----------------------------------------------------------
`ifndef SOBEL_PARAMS_SVH
`define SOBEL_PARAMS_SVH

// Bus widths
`define SOBEL_ADDR_W 32
`define SOBEL_DATA_W 32

// Pixel and result width, window size
`define SOBEL_PIX_W 12
`define SOBEL_TAPS 9

// Virtual LED and DIP width
`define SOBEL_LED_W 16

// Register map
// Result on read, scratch on write
`define SOBEL_RESULT_ADDR 32'h0000_0000
`define SOBEL_VLED_ADDR 32'h0000_0004
// Pixel k at base + 4*k
`define SOBEL_PIX_BASE_ADDR 32'h0000_0010
`define SOBEL_MODE_ADDR 32'h0000_0040

// Returned for any address without read-back
`define SOBEL_UNIMPL_VALUE 32'hDEAD_BEEF

`endif

/* hw/sobel_pkg.sv */
//----------------------------------------------------------
// Sobel edge engine shared types
//----------------------------------------------------------
`include "sobel_params.svh"

package sobel_pkg;

  // Signed pixel, also used for the filter result
  typedef logic signed [`SOBEL_PIX_W-1:0] pix_t;

  // 3x3 window, row-major, element 0 at top left
  typedef pix_t [`SOBEL_TAPS-1:0] pix_win_t;

  // AXI response code
  typedef logic [1:0] axi_resp_t;

  // Only response ever returned
  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

/* hw/axil_reg_port.sv */
//----------------------------------------------------------
// Single-beat AXI-Lite slave
// Turns bus writes into register strobes, reads into requests
//----------------------------------------------------------
`timescale 1ns/1ns
`include "sobel_params.svh"

module axil_reg_port (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  // Write address channel
  input  logic                       awvalid,
  input  logic [`SOBEL_ADDR_W-1:0]   awaddr,
  output logic                       awready,
  // Write data channel
  input  logic                       wvalid,
  input  logic [`SOBEL_DATA_W-1:0]   wdata,
  output logic                       wready,
  // Write response channel
  output logic                       bvalid,
  output sobel_pkg::axi_resp_t       bresp,
  input  logic                       bready,
  // Read address channel
  input  logic                       arvalid,
  input  logic [`SOBEL_ADDR_W-1:0]   araddr,
  output logic                       arready,
  // Read data channel
  output logic                       rvalid,
  output logic [`SOBEL_DATA_W-1:0]   rdata,
  output sobel_pkg::axi_resp_t       rresp,
  input  logic                       rready,
  // Register side
  output logic                       wr_en,
  output logic [`SOBEL_ADDR_W-1:0]   wr_addr,
  output logic [`SOBEL_DATA_W-1:0]   wr_data,
  output logic                       rd_en,
  output logic [`SOBEL_ADDR_W-1:0]   rd_addr,
  input  logic [`SOBEL_DATA_W-1:0]   rd_data
);

  logic wr_active;
  logic rd_pending;

  //----------------------------------------------------------
  // Write path
  //----------------------------------------------------------
  // One write in flight, open from aw until b handshake
  assign awready = ~wr_active;
  // Data taken once per write, never while response waits
  assign wready  = wr_active & wvalid & ~bvalid;
  assign wr_en   = wready;
  assign wr_data = wdata;
  assign bresp   = sobel_pkg::RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      if (bvalid && bready) begin
        wr_active <= 1'b0;
      end else if (awvalid && awready) begin
        wr_active <= 1'b1;
      end
      // Response one cycle after the data beat
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (wready) begin
        bvalid <= 1'b1;
      end
    end
  end

  // Address held for the whole write
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr <= awaddr;
    end
  end

  //----------------------------------------------------------
  // Read path
  //----------------------------------------------------------
  // Blocked while a request or a response is outstanding
  assign arready = ~rd_pending & ~rvalid;
  assign rd_en   = rd_pending;
  assign rresp   = sobel_pkg::RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pending <= 1'b0;
      rvalid     <= 1'b0;
    end else begin
      // Pending lasts exactly one cycle
      if (rd_pending) begin
        rd_pending <= 1'b0;
      end else if (arvalid && arready) begin
        rd_pending <= 1'b1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (rd_pending) begin
        rvalid <= 1'b1;
      end
    end
  end

  // Address captured only on the ar handshake
  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr <= araddr;
    end
    // Register snapshot at the request cycle
    if (rd_pending) begin
      rdata <= rd_data;
    end
  end

  // Write response held under back-pressure
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid);

  // Read response and its data held until taken
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata));

  // One data beat per write, none once the write has closed
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready || (bvalid && bready) |=> !wready);

endmodule

/* hw/conv_regs.sv */
//----------------------------------------------------------
// Sobel register file
// Pixel, mode and scratch registers plus read-data mux
//----------------------------------------------------------
`timescale 1ns/1ns
`include "sobel_params.svh"

module conv_regs (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  // Write strobe from bus port
  input  logic                       wr_en,
  input  logic [`SOBEL_ADDR_W-1:0]   wr_addr,
  input  logic [`SOBEL_DATA_W-1:0]   wr_data,
  // Read request from bus port
  input  logic                       rd_en,
  input  logic [`SOBEL_ADDR_W-1:0]   rd_addr,
  output logic [`SOBEL_DATA_W-1:0]   rd_data,
  // Filter side
  output sobel_pkg::pix_win_t        pix_win,
  output logic                       is_horz,
  input  sobel_pkg::pix_t            result,
  // LED side
  output logic [`SOBEL_LED_W-1:0]    led_src,
  input  logic [`SOBEL_LED_W-1:0]    shadow
);

  logic [`SOBEL_DATA_W-1:0] mode_q;
  logic [`SOBEL_LED_W-1:0]  scratch_q;

  //----------------------------------------------------------
  // Write decode
  //----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      pix_win   <= '0;
      mode_q    <= '0;
      scratch_q <= '0;
    end else if (wr_en) begin
      // Nine pixel slots, 4 bytes apart
      for (int k = 0; k < `SOBEL_TAPS; k++) begin
        if (wr_addr == `SOBEL_PIX_BASE_ADDR + 4 * k) begin
          pix_win[k] <= sobel_pkg::pix_t'(wr_data[`SOBEL_PIX_W-1:0]);
        end
      end
      if (wr_addr == `SOBEL_MODE_ADDR) begin
        mode_q <= wr_data;
      end
      // Only the LED bits of the scratch word are kept
      if (wr_addr == `SOBEL_RESULT_ADDR) begin
        scratch_q <= wr_data[`SOBEL_LED_W-1:0];
      end
    end
  end

  // Any nonzero mode selects horizontal kernel
  assign is_horz = |mode_q;
  assign led_src = scratch_q;

  //----------------------------------------------------------
  // Read mux
  //----------------------------------------------------------
  always_comb begin
    if (!rd_en) begin
      rd_data = '0;
    end else if (rd_addr == `SOBEL_RESULT_ADDR) begin
      // Result bits zero-extended, no sign
      rd_data = {{(`SOBEL_DATA_W - `SOBEL_PIX_W){1'b0}}, result};
    end else if (rd_addr == `SOBEL_VLED_ADDR) begin
      rd_data = {{(`SOBEL_DATA_W - `SOBEL_LED_W){1'b0}}, shadow};
    end else begin
      // Pixel, mode and scratch are write-only
      rd_data = `SOBEL_UNIMPL_VALUE;
    end
  end

  // Strobes from the bus port always resolved
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !$isunknown({rd_en, wr_en}));

endmodule

/* hw/sobel_filter.sv */
//----------------------------------------------------------
// 3x3 Sobel convolution, combinational
// Kernel picked by mode, result truncated to pixel width
//----------------------------------------------------------
`timescale 1ns/1ns
`include "sobel_params.svh"

module sobel_filter (
  input  sobel_pkg::pix_win_t pix_win,
  input  logic                is_horz,
  output sobel_pkg::pix_t     result
);

  // Enough headroom for nine products of magnitude up to 2
  localparam int ACC_W = `SOBEL_PIX_W + 4;

  // Coefficients c0..c8, row-major
  localparam logic signed [2:0] C_HORZ [`SOBEL_TAPS] = '{
    -3'sd1, -3'sd2, -3'sd1,
     3'sd0,  3'sd0,  3'sd0,
     3'sd1,  3'sd2,  3'sd1
  };
  localparam logic signed [2:0] C_VERT [`SOBEL_TAPS] = '{
    -3'sd1,  3'sd0,  3'sd1,
    -3'sd2,  3'sd0,  3'sd2,
    -3'sd1,  3'sd0,  3'sd1
  };

  logic signed [2:0]       coef [`SOBEL_TAPS];
  logic signed [ACC_W-1:0] acc;

  // Mode select per tap
  always_comb begin
    for (int k = 0; k < `SOBEL_TAPS; k++) begin
      coef[k] = is_horz ? C_HORZ[k] : C_VERT[k];
    end
  end

  //----------------------------------------------------------
  // Multiply-accumulate
  //----------------------------------------------------------
  // Kernel rotated by 180 degrees, pixel k meets coefficient 8-k
  always_comb begin
    acc = '0;
    for (int k = 0; k < `SOBEL_TAPS; k++) begin
      acc = acc + sobel_pkg::pix_t'(pix_win[k]) * coef[`SOBEL_TAPS - 1 - k];
    end
  end

  // Two's complement wrap to pixel width
  assign result = sobel_pkg::pix_t'(acc[`SOBEL_PIX_W-1:0]);

endmodule

/* hw/vled_ctrl.sv */
//----------------------------------------------------------
// Virtual LED control
// DIP synchronizer, LED shadow and masked LED output
//----------------------------------------------------------
`timescale 1ns/1ns
`include "sobel_params.svh"

module vled_ctrl (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  logic [`SOBEL_LED_W-1:0] led_src,
  input  logic [`SOBEL_LED_W-1:0] vdip,
  output logic [`SOBEL_LED_W-1:0] shadow,
  output logic [`SOBEL_LED_W-1:0] vled
);

  logic [`SOBEL_LED_W-1:0] dip_meta;
  logic [`SOBEL_LED_W-1:0] dip_sync;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      dip_meta <= '0;
      dip_sync <= '0;
      shadow   <= '0;
      vled     <= '0;
    end else begin
      // Two-flop synchronizer, DIPs are asynchronous
      dip_meta <= vdip;
      dip_sync <= dip_meta;
      // Shadow follows the scratch LED bits
      shadow   <= led_src;
      // Registered output, LEDs lit only where DIP is on
      vled     <= shadow & dip_sync;
    end
  end

endmodule

/* hw/sobel_conv_top.sv */
//----------------------------------------------------------
// Sobel edge engine top
// Bus port, register file, filter and virtual LEDs
//----------------------------------------------------------
`timescale 1ns/1ns
`include "sobel_params.svh"

module sobel_conv_top (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  logic                       awvalid,
  input  logic [`SOBEL_ADDR_W-1:0]   awaddr,
  output logic                       awready,
  input  logic                       wvalid,
  input  logic [`SOBEL_DATA_W-1:0]   wdata,
  output logic                       wready,
  output logic                       bvalid,
  output sobel_pkg::axi_resp_t       bresp,
  input  logic                       bready,
  input  logic                       arvalid,
  input  logic [`SOBEL_ADDR_W-1:0]   araddr,
  output logic                       arready,
  output logic                       rvalid,
  output logic [`SOBEL_DATA_W-1:0]   rdata,
  output sobel_pkg::axi_resp_t       rresp,
  input  logic                       rready,
  input  logic [`SOBEL_LED_W-1:0]    vdip,
  output logic [`SOBEL_LED_W-1:0]    vled
);

  // Port to register file
  logic                     wr_en;
  logic [`SOBEL_ADDR_W-1:0] wr_addr;
  logic [`SOBEL_DATA_W-1:0] wr_data;
  logic                     rd_en;
  logic [`SOBEL_ADDR_W-1:0] rd_addr;
  logic [`SOBEL_DATA_W-1:0] rd_data;
  // Register file to filter and LEDs
  sobel_pkg::pix_win_t      pix_win;
  logic                     is_horz;
  sobel_pkg::pix_t          result;
  logic [`SOBEL_LED_W-1:0]  led_src;
  logic [`SOBEL_LED_W-1:0]  shadow;

  axil_reg_port u_port (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  conv_regs u_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .pix_win         (pix_win),
    .is_horz         (is_horz),
    .result          (result),
    .led_src         (led_src),
    .shadow          (shadow)
  );

  sobel_filter u_filter (
    .pix_win (pix_win),
    .is_horz (is_horz),
    .result  (result)
  );

  vled_ctrl u_vled (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .led_src         (led_src),
    .vdip            (vdip),
    .shadow          (shadow),
    .vled            (vled)
  );

endmodule

/* tests/tb_sobel_conv.sv */
//----------------------------------------------------------
// Sobel edge engine testbench
// Random register traffic checked against a reference model
//----------------------------------------------------------
`timescale 1ns/1ns
`include "sobel_params.svh"

module tb_sobel_conv;

  localparam int TIMEOUT = 50;
  // Kernel coefficients c0..c8, row-major
  localparam int COEF_H [9] = '{-1, -2, -1, 0, 0, 0, 1, 2, 1};
  localparam int COEF_V [9] = '{-1, 0, 1, -2, 0, 2, -1, 0, 1};

  logic        clk_main_a0 = 1'b0;
  logic        rst_main_n_sync;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [15:0] vdip, vled;
  sobel_pkg::axi_resp_t bresp, rresp;

  // Reference model state
  integer      seed;
  int          pix_m [9];
  logic [31:0] mode_m;
  logic [15:0] scratch_m;

  always #5 clk_main_a0 = ~clk_main_a0;

  sobel_conv_top UUT (.*);

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s at %0t ns", what, $time);
    $display("TEST FAILED");
    $fatal(1, "handshake timeout");
  endtask

  // Convolution with the kernel rotated by 180 degrees, 12-bit wrap
  function automatic logic [31:0] expected_result();
    int sum;
    sum = 0;
    for (int k = 0; k < 9; k++) begin
      sum += pix_m[k] * ((mode_m != 0) ? COEF_H[8-k] : COEF_V[8-k]);
    end
    return {20'd0, sum[11:0]};
  endfunction

  //----------------------------------------------------------
  // Bus tasks
  //----------------------------------------------------------
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input int stall);
    int n;
    @(posedge clk_main_a0);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    n = 0;
    do begin
      @(negedge clk_main_a0);
      if (++n > TIMEOUT) report_timeout("awready");
    end while (!awready);
    @(posedge clk_main_a0);
    awvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_main_a0);
      if (++n > TIMEOUT) report_timeout("wready");
    end while (!wready);
    @(posedge clk_main_a0);
    wvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_main_a0);
      if (++n > TIMEOUT) report_timeout("bvalid");
    end while (!bvalid);
    check_value("bresp", 32'(bresp), 32'd0);
    // Response must sit still while bready is low
    repeat (stall) begin
      @(negedge clk_main_a0);
      check_value("bvalid held", 32'(bvalid), 32'd1);
      check_value("awready held low", 32'(awready), 32'd0);
    end
    @(posedge clk_main_a0);
    bready <= 1'b1;
    @(posedge clk_main_a0);
    bready <= 1'b0;
    @(negedge clk_main_a0);
    check_value("bvalid after b handshake", 32'(bvalid), 32'd0);
    check_value("awready after b handshake", 32'(awready), 32'd1);
  endtask

  task automatic bus_read(input logic [31:0] addr, input int stall, output logic [31:0] data);
    int n;
    @(posedge clk_main_a0);
    arvalid <= 1'b1;
    araddr  <= addr;
    n = 0;
    do begin
      @(negedge clk_main_a0);
      if (++n > TIMEOUT) report_timeout("arready");
    end while (!arready);
    @(posedge clk_main_a0);
    arvalid <= 1'b0;
    // rvalid two edges after the address edge
    n = 0;
    do begin
      @(negedge clk_main_a0);
      if (++n > TIMEOUT) report_timeout("rvalid");
    end while (!rvalid);
    check_value("read latency", 32'(n), 32'd2);
    check_value("rresp", 32'(rresp), 32'd0);
    data = rdata;
    repeat (stall) begin
      @(negedge clk_main_a0);
      check_value("rvalid held", 32'(rvalid), 32'd1);
      check_value("rdata held", rdata, data);
      check_value("arready held low", 32'(arready), 32'd0);
    end
    @(posedge clk_main_a0);
    rready <= 1'b1;
    @(posedge clk_main_a0);
    rready <= 1'b0;
    @(negedge clk_main_a0);
    check_value("rvalid after r handshake", 32'(rvalid), 32'd0);
    check_value("arready after r handshake", 32'(arready), 32'd1);
  endtask

  task automatic write_pixel(input int k, input logic [31:0] data, input int stall);
    bus_write(`SOBEL_PIX_BASE_ADDR + 32'(4 * k), data, stall);
    // Only the low 12 bits are kept, signed
    pix_m[k] = int'($signed(data[11:0]));
  endtask

  task automatic write_mode(input logic [31:0] data);
    bus_write(`SOBEL_MODE_ADDR, data, 0);
    mode_m = data;
  endtask

  //----------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------
  initial begin
    int          k;
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] addr;
    logic [15:0] dip;
    seed = 32'h252c;
    rst_main_n_sync = 1'b0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    {awaddr, wdata, araddr} = '0;
    vdip = '0;
    for (int i = 0; i < 9; i++) pix_m[i] = 0;
    mode_m = '0;
    scratch_m = '0;
    repeat (5) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;

    // Idle state after reset
    @(negedge clk_main_a0);
    check_value("awready after reset", 32'(awready), 32'd1);
    check_value("arready after reset", 32'(arready), 32'd1);
    check_value("bvalid after reset", 32'(bvalid), 32'd0);
    check_value("rvalid after reset", 32'(rvalid), 32'd0);
    check_value("wready after reset", 32'(wready), 32'd0);
    check_value("vled after reset", 32'(vled), 32'd0);
    bus_read(`SOBEL_RESULT_ADDR, 0, rd);
    check_value("result after reset", rd, 32'd0);

    // Directed window whose sum overflows 12 bits
    for (int i = 0; i < 9; i++) begin
      write_pixel(i, (i < 3) ? 32'h7FF : ((i > 5) ? 32'h800 : 32'h0), 0);
    end
    write_mode(32'd1);
    bus_read(`SOBEL_RESULT_ADDR, 0, rd);
    check_value("wrapped result", rd, expected_result());

    // Random windows, mode zero or nonzero
    repeat (60) begin
      for (int i = 0; i < 9; i++) write_pixel(i, $random(seed), 0);
      data = $random(seed);
      if (data[4]) data = '0;
      write_mode(data);
      bus_read(`SOBEL_RESULT_ADDR, 0, rd);
      check_value("result", rd, expected_result());
    end

    // Write-only and unmapped addresses
    for (int i = 0; i < 9; i++) begin
      bus_read(`SOBEL_PIX_BASE_ADDR + 32'(4 * i), 0, rd);
      check_value("pixel read-back", rd, `SOBEL_UNIMPL_VALUE);
    end
    bus_read(`SOBEL_MODE_ADDR, 0, rd);
    check_value("mode read-back", rd, `SOBEL_UNIMPL_VALUE);
    repeat (10) begin
      addr = $random(seed) & 32'h0000_0FFC;
      if (addr == `SOBEL_RESULT_ADDR || addr == `SOBEL_VLED_ADDR) addr = 32'h8;
      bus_read(addr, 0, rd);
      check_value("unmapped read", rd, `SOBEL_UNIMPL_VALUE);
    end

    // Scratch to LEDs, masked by synchronized DIPs
    repeat (10) begin
      data = $random(seed);
      bus_write(`SOBEL_RESULT_ADDR, data, 0);
      scratch_m = data[15:0];
      dip = 16'($random(seed));
      @(posedge clk_main_a0);
      vdip <= dip;
      repeat (3) @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      check_value("vled", 32'(vled), 32'(scratch_m & dip));
      bus_read(`SOBEL_VLED_ADDR, 0, rd);
      check_value("vled read-back", rd, {16'd0, scratch_m});
    end

    // Back-pressure on both response channels
    repeat (20) begin
      k = ($random(seed) & 32'h7FFF_FFFF) % 9;
      write_pixel(k, $random(seed), ($random(seed) & 7) + 1);
      bus_read(`SOBEL_RESULT_ADDR, ($random(seed) & 7) + 1, rd);
      check_value("result under back-pressure", rd, expected_result());
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* sobel_conv.f */
+incdir+hw
hw/sobel_pkg.sv
hw/axil_reg_port.sv
hw/conv_regs.sv
hw/sobel_filter.sv
hw/vled_ctrl.sv
hw/sobel_conv_top.sv
tests/tb_sobel_conv.sv

/* Makefile */
# Verilator build and run for the Sobel edge engine

VERILATOR ?= verilator
TOP       ?= tb_sobel_conv
RTL_TOP   ?= sobel_conv_top
FILELIST  ?= sobel_conv.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
